//--- hdl/chanlink_pkg.sv
package chanlink_pkg;

	////////////////////////////////////////////////////////////
	// Widths and frame layout
	////////////////////////////////////////////////////////////
	localparam int SAMPLE_W  = 12;
	localparam int WORD_W    = 16;
	localparam int CRC_W     = 15;
	localparam int L1A_CNT_W = 24;
	localparam int OCC_W     = 5;
	localparam int SEQ_W     = 7;

	localparam int HDR_WORDS    = 4;
	localparam int DATA_WORDS   = 96;
	localparam int TRL_WORDS    = 4;
	localparam int SERIAL_FIRST = 72;   // L1A phase window
	localparam int SERIAL_LAST  = 77;

	localparam int EVT_DEPTH = 512;
	localparam int L1A_DEPTH = 8;
	localparam int EVT_CNT_W = $clog2(EVT_DEPTH + 1);

	// Slot numbers where the sequencer changes phase
	localparam logic [SEQ_W-1:0] SEQ_HDR_LAST  = SEQ_W'(HDR_WORDS - 1);
	localparam logic [SEQ_W-1:0] SEQ_DATA_LAST = SEQ_W'(DATA_WORDS - 1);
	localparam logic [SEQ_W-1:0] SEQ_TRL_FIRST = SEQ_W'(DATA_WORDS);
	localparam logic [SEQ_W-1:0] SEQ_TRL_LAST  = SEQ_W'(DATA_WORDS + TRL_WORDS - 1);

	localparam logic [WORD_W-1:0] HDR_MARK0 = 16'hc4b4;
	localparam logic [WORD_W-1:0] HDR_MARK1 = 16'hc5b5;
	localparam logic [WORD_W-1:0] TRL_MARK0 = 16'h700C;
	localparam logic [WORD_W-1:0] TRL_MARK1 = 16'h7FFF;
	localparam logic [3:0]        TRL_STAT_NIBBLE = 4'h7;

	////////////////////////////////////////////////////////////
	// Types
	////////////////////////////////////////////////////////////
	typedef logic [WORD_W-1:0]   word_t;
	typedef logic [SAMPLE_W-1:0] sample_t;
	typedef logic [CRC_W-1:0]    crc_t;

	typedef struct packed {
		logic       mlt_ovlp;
		logic       ovlp;
		logic [3:0] ocnt;       // Not used by the framer
		sample_t    sample;
	} evt_word_t;

	typedef struct packed {
		logic                 phase;
		logic [L1A_CNT_W-1:0] num;
	} l1a_info_t;

	typedef struct packed {
		logic             valid;
		logic             hdr;
		logic [SEQ_W-1:0] seq;
		logic             last;
	} frame_slot_t;

	// One CRC-15 update over 13 data bits
	function automatic crc_t crc15_step(input logic [SAMPLE_W:0] d, input crc_t c);
		crc_t n;
		n[0] = d[0] ^ c[2];
		for (int k = 1; k <= 12; k++) begin
			n[k] = d[k-1] ^ d[k] ^ c[k+1] ^ c[k+2];
		end
		n[13] = d[12] ^ c[14] ^ c[0];
		n[14] = c[1];
		return n;
	endfunction

endpackage

//--- hdl/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
	parameter type T     = logic [7:0],
	parameter int  DEPTH = 16              // Power of two
) (
	input  logic                       RCLK,
	input  logic                       RST_RESYNC,
	input  logic                       push_i,
	input  T                           wdata_i,
	input  logic                       pop_i,
	output T                           head_o,
	output logic                       empty_o,
	output logic [$clog2(DEPTH+1)-1:0] count_o
);

	T mem [DEPTH];

	logic [$clog2(DEPTH)-1:0] wr_ptr;
	logic [$clog2(DEPTH)-1:0] rd_ptr;
	logic                     full;

	assign full    = (count_o == $bits(count_o)'(DEPTH));
	assign empty_o = (count_o == '0);
	assign head_o  = mem[rd_ptr];   // Show-ahead

	always_ff @(posedge RCLK) begin
		if (push_i) begin
			mem[wr_ptr] <= wdata_i;
		end
	end

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count_o <= '0;
		end else begin
			if (push_i) begin
				wr_ptr <= wr_ptr + 1'b1;   // Wraps at DEPTH
			end
			if (pop_i) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push_i, pop_i})
				2'b10:   count_o <= count_o + 1'b1;
				2'b01:   count_o <= count_o - 1'b1;
				default: count_o <= count_o;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Usage checks
	////////////////////////////////////////////////////////////
	a_no_overflow : assert property (
		@(posedge RCLK) disable iff (RST_RESYNC) push_i |-> !full
	) else $error("push into full FIFO");

	a_no_underflow : assert property (
		@(posedge RCLK) disable iff (RST_RESYNC) pop_i |-> !empty_o
	) else $error("pop from empty FIFO");

endmodule

//--- hdl/frame_sequencer.sv
`timescale 1ns/1ps

module frame_sequencer
	import chanlink_pkg::*;
(
	input  logic                 RCLK,
	input  logic                 RST_RESYNC,
	input  logic                 l1a_empty_i,
	input  logic [EVT_CNT_W-1:0] evt_count_i,
	output logic                 evt_pop_o,
	output logic                 l1a_pop_o,
	output frame_slot_t          slot_o
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_HDR,
		S_DATA,
		S_TRL,
		S_GAP
	} state_t;

	state_t           state_q;
	logic [SEQ_W-1:0] seq_q;
	logic             start;

	// Whole event and its trigger record stored
	assign start = !l1a_empty_i && (evt_count_i >= EVT_CNT_W'(DATA_WORDS));

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			state_q <= S_IDLE;
			seq_q   <= '0;
		end else begin
			case (state_q)
				S_IDLE: begin
					seq_q <= '0;
					if (start) begin
						state_q <= S_HDR;
					end
				end
				S_HDR: begin
					if (seq_q == SEQ_HDR_LAST) begin
						state_q <= S_DATA;
						seq_q   <= '0;     // Data restarts at 0
					end else begin
						seq_q <= seq_q + 1'b1;
					end
				end
				S_DATA: begin
					seq_q <= seq_q + 1'b1;  // Runs on into trailer numbers
					if (seq_q == SEQ_DATA_LAST) begin
						state_q <= S_TRL;
					end
				end
				S_TRL: begin
					if (seq_q == SEQ_TRL_LAST) begin
						state_q <= S_GAP;
						seq_q   <= '0;
					end else begin
						seq_q <= seq_q + 1'b1;
					end
				end
				default: begin
					state_q <= S_IDLE;    // One dead cycle between frames
					seq_q   <= '0;
				end
			endcase
		end
	end

	assign slot_o.valid = (state_q == S_HDR) || (state_q == S_DATA) || (state_q == S_TRL);
	assign slot_o.hdr   = (state_q == S_HDR);
	assign slot_o.seq   = seq_q;
	assign slot_o.last  = (state_q == S_TRL) && (seq_q == SEQ_TRL_LAST);

	assign evt_pop_o = (state_q == S_DATA);
	assign l1a_pop_o = slot_o.last;       // Record freed with the final word

	////////////////////////////////////////////////////////////
	// Protocol checks against the FIFO levels
	////////////////////////////////////////////////////////////
	a_evt_not_empty : assert property (
		@(posedge RCLK) disable iff (RST_RESYNC) evt_pop_o |-> (evt_count_i != '0)
	) else $error("event FIFO popped while empty");

	a_l1a_held : assert property (
		@(posedge RCLK) disable iff (RST_RESYNC) slot_o.valid |-> !l1a_empty_i
	) else $error("frame running without an L1A record");

endmodule

//--- hdl/frame_builder.sv
`timescale 1ns/1ps

module frame_builder
	import chanlink_pkg::*;
(
	input  logic        RCLK,
	input  logic        RST_RESYNC,
	input  frame_slot_t slot_i,
	input  evt_word_t   evt_head_i,
	input  l1a_info_t   l1a_head_i,
	input  logic        l1a_push_i,
	input  logic        warn_i,
	output word_t       dout_o,
	output logic        dvalid_o,
	output logic        last_wrd_o,
	output logic        ovlp_mux_o,
	output logic        mlt_ovlp_o
);

	logic             in_data;
	logic             is_data;
	logic             serial;
	word_t            data_word;
	word_t            hdr_word;
	word_t            trl_word;
	word_t            next_word;
	crc_t             crc_q;
	logic [OCC_W-1:0] occ_q;

	assign in_data = !slot_i.hdr && (slot_i.seq < SEQ_TRL_FIRST);
	assign is_data = slot_i.valid && in_data;

	// L1A phase rides in a fixed window of data slots
	assign serial = (slot_i.seq >= SEQ_W'(SERIAL_FIRST)) &&
			(slot_i.seq <= SEQ_W'(SERIAL_LAST)) && l1a_head_i.phase;

	assign data_word = {1'b0, ~evt_head_i.ovlp, serial, 1'b0, evt_head_i.sample};

	////////////////////////////////////////////////////////////
	// Header and trailer words
	////////////////////////////////////////////////////////////
	always_comb begin
		case (slot_i.seq[1:0])
			2'd0:    hdr_word = HDR_MARK0;
			2'd1:    hdr_word = {4'h0, l1a_head_i.num[11:0]};
			2'd2:    hdr_word = {4'h0, l1a_head_i.num[23:12]};
			default: hdr_word = HDR_MARK1;
		endcase
	end

	always_comb begin
		case (slot_i.seq)
			SEQ_TRL_FIRST:              trl_word = {1'b0, crc_q};
			SEQ_TRL_FIRST + SEQ_W'(1):  trl_word = TRL_MARK0;
			SEQ_TRL_FIRST + SEQ_W'(2):  trl_word = {TRL_STAT_NIBBLE, l1a_head_i.num[5:0],
								occ_q, warn_i};
			default:                    trl_word = TRL_MARK1;
		endcase
	end

	assign next_word = slot_i.hdr ? hdr_word : (in_data ? data_word : trl_word);

	////////////////////////////////////////////////////////////
	// Output stage
	////////////////////////////////////////////////////////////
	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			dvalid_o   <= 1'b0;
			last_wrd_o <= 1'b0;
			ovlp_mux_o <= 1'b0;
			mlt_ovlp_o <= 1'b0;
		end else begin
			dvalid_o   <= slot_i.valid;
			last_wrd_o <= slot_i.valid && slot_i.last;
			ovlp_mux_o <= is_data && evt_head_i.ovlp;      // Zero outside data
			mlt_ovlp_o <= is_data && evt_head_i.mlt_ovlp;
		end
	end

	always_ff @(posedge RCLK) begin
		if (slot_i.valid) begin
			dout_o <= next_word;
		end
	end

	// CRC restarts each header, one step per sample
	always_ff @(posedge RCLK) begin
		if (slot_i.valid && slot_i.hdr) begin
			crc_q <= '0;
		end else if (is_data) begin
			crc_q <= crc15_step({1'b0, evt_head_i.sample}, crc_q);
		end
	end

	// Outstanding L1A records
	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			occ_q <= '0;
		end else if (l1a_push_i && !last_wrd_o) begin
			occ_q <= occ_q + OCC_W'(1);
		end else if (last_wrd_o && !l1a_push_i) begin
			occ_q <= occ_q - OCC_W'(1);
		end
	end

	a_occ_no_overflow : assert property (
		@(posedge RCLK) disable iff (RST_RESYNC)
		(l1a_push_i && !last_wrd_o) |-> (occ_q != '1)
	) else $error("L1A occupancy overflow");

	a_occ_no_underflow : assert property (
		@(posedge RCLK) disable iff (RST_RESYNC)
		(last_wrd_o && !l1a_push_i) |-> (occ_q != '0)
	) else $error("frame closed with no L1A outstanding");

endmodule

//--- hdl/chanlink_readout.sv
`timescale 1ns/1ps

module chanlink_readout
	import chanlink_pkg::*;
(
	input  logic      RCLK,
	input  logic      RST_RESYNC,
	input  evt_word_t evt_wdata_i,
	input  logic      evt_wren_i,
	input  l1a_info_t l1a_wdata_i,
	input  logic      l1a_wren_i,
	input  logic      warn_i,
	output word_t     dout_o,
	output logic      dvalid_o,
	output logic      last_wrd_o,
	output logic      ovlp_mux_o,
	output logic      mlt_ovlp_o
);

	evt_word_t            evt_head;
	l1a_info_t            l1a_head;
	logic [EVT_CNT_W-1:0] evt_count;
	logic                 l1a_empty;
	logic                 evt_pop;
	logic                 l1a_pop;
	frame_slot_t          slot;

	sync_fifo #(.T(evt_word_t), .DEPTH(EVT_DEPTH)) evt_fifo_i (
		.RCLK       (RCLK),
		.RST_RESYNC (RST_RESYNC),
		.push_i     (evt_wren_i),
		.wdata_i    (evt_wdata_i),
		.pop_i      (evt_pop),
		.head_o     (evt_head),
		.empty_o    (),
		.count_o    (evt_count)
	);

	sync_fifo #(.T(l1a_info_t), .DEPTH(L1A_DEPTH)) l1a_fifo_i (
		.RCLK       (RCLK),
		.RST_RESYNC (RST_RESYNC),
		.push_i     (l1a_wren_i),
		.wdata_i    (l1a_wdata_i),
		.pop_i      (l1a_pop),
		.head_o     (l1a_head),
		.empty_o    (l1a_empty),
		.count_o    ()
	);

	frame_sequencer seq_i (
		.RCLK        (RCLK),
		.RST_RESYNC  (RST_RESYNC),
		.l1a_empty_i (l1a_empty),
		.evt_count_i (evt_count),
		.evt_pop_o   (evt_pop),
		.l1a_pop_o   (l1a_pop),
		.slot_o      (slot)
	);

	frame_builder bld_i (
		.RCLK        (RCLK),
		.RST_RESYNC  (RST_RESYNC),
		.slot_i      (slot),
		.evt_head_i  (evt_head),
		.l1a_head_i  (l1a_head),
		.l1a_push_i  (l1a_wren_i),
		.warn_i      (warn_i),
		.dout_o      (dout_o),
		.dvalid_o    (dvalid_o),
		.last_wrd_o  (last_wrd_o),
		.ovlp_mux_o  (ovlp_mux_o),
		.mlt_ovlp_o  (mlt_ovlp_o)
	);

endmodule

//--- test/chanlink_checks.svh
`ifndef CHANLINK_CHECKS_SVH
`define CHANLINK_CHECKS_SVH

////////////////////////////////////////////////////////////
// Reference model of one frame word
////////////////////////////////////////////////////////////
function automatic word_t model_word(
	input int               idx,
	input l1a_info_t        l1a,
	input evt_word_t        ev,
	input crc_t             crc,
	input logic [OCC_W-1:0] occ,
	input logic             warn_bit
);
	int    s;
	logic  ser;
	word_t w;
	s   = idx - HDR_WORDS;                                        // Data seq
	ser = (s >= SERIAL_FIRST) && (s <= SERIAL_LAST) && l1a.phase;
	if (idx < HDR_WORDS) begin
		case (idx)
			0:       w = HDR_MARK0;
			1:       w = {4'h0, l1a.num[11:0]};
			2:       w = {4'h0, l1a.num[23:12]};
			default: w = HDR_MARK1;
		endcase
	end else if (s < DATA_WORDS) begin
		w = {1'b0, ~ev.ovlp, ser, 1'b0, ev.sample};
	end else begin
		case (s - DATA_WORDS)
			0:       w = {1'b0, crc};
			1:       w = TRL_MARK0;
			2:       w = {TRL_STAT_NIBBLE, l1a.num[5:0], occ, warn_bit};   // Status word
			default: w = TRL_MARK1;
		endcase
	end
	return w;
endfunction

////////////////////////////////////////////////////////////
// Compare tasks
////////////////////////////////////////////////////////////
task automatic check_word(input string name, input word_t got, input word_t exp);
	if (got !== exp) begin
		fail_run($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
	end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		fail_run($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
	end
endtask

task automatic check_crc(input string name, input crc_t got, input crc_t exp);
	if (got !== exp) begin
		fail_run($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
	end
endtask

`endif

//--- test/chanlink_tb.sv
`timescale 1ns/1ps

module chanlink_tb
	import chanlink_pkg::*;
();

	localparam int          N_EVENTS      = 12;
	localparam int          MAX_UNREAD    = 4;
	localparam int          FRAME_WORDS   = HDR_WORDS + DATA_WORDS + TRL_WORDS;
	localparam int          ROOM_TIMEOUT  = 2000;
	localparam int          FRAME_TIMEOUT = 4000;
	localparam logic [31:0] LFSR_SEED     = 32'he394_4aa0;
	localparam logic [31:0] LFSR_TAPS     = 32'h8020_0003;

	logic      RCLK;
	logic      RST_RESYNC;
	evt_word_t evt_wdata;
	logic      evt_wren;
	l1a_info_t l1a_wdata;
	logic      l1a_wren;
	logic      warn;
	word_t     dout;
	logic      dvalid;
	logic      last_wrd;
	logic      ovlp_mux;
	logic      mlt_ovlp;

	logic [31:0] lfsr_q;
	evt_word_t   evt_q[$];         // Pushed samples not yet seen on dout
	l1a_info_t   l1a_q[$];
	l1a_info_t   cur_l1a;
	crc_t        crc_m;
	int          word_idx;
	int          frames_done;
	int          events_pushed;
	int          l1a_pushes;
	int          lasts_seen;
	logic        prev_valid;

	chanlink_readout dut_i (
		.RCLK        (RCLK),
		.RST_RESYNC  (RST_RESYNC),
		.evt_wdata_i (evt_wdata),
		.evt_wren_i  (evt_wren),
		.l1a_wdata_i (l1a_wdata),
		.l1a_wren_i  (l1a_wren),
		.warn_i      (warn),
		.dout_o      (dout),
		.dvalid_o    (dvalid),
		.last_wrd_o  (last_wrd),
		.ovlp_mux_o  (ovlp_mux),
		.mlt_ovlp_o  (mlt_ovlp)
	);

	initial begin
		RCLK = 1'b0;
		forever #20 RCLK = ~RCLK;
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1, "simulation stopped");
	endtask

	`include "chanlink_checks.svh"

	// Galois LFSR stepped once per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int k = 0; k < n; k++) begin
			r[k]   = lfsr_q[0];
			lfsr_q = {1'b0, lfsr_q[31:1]} ^ (lfsr_q[0] ? LFSR_TAPS : 32'h0);
		end
		return r;
	endfunction

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////
	task automatic next_cycle();
		@(posedge RCLK);
		#2;
		evt_wren = 1'b0;
		l1a_wren = 1'b0;
		if (rand_bits(3) == 0) begin
			warn = ~warn;
		end
	endtask

	task automatic push_event();
		logic [31:0] r;
		for (int i = 0; i < DATA_WORDS; i++) begin
			if (rand_bits(2) == 0) begin
				next_cycle();                                         // Short gap
			end
			next_cycle();
			r         = rand_bits($bits(evt_word_t));
			evt_wdata = r[$bits(evt_word_t)-1:0];
			evt_wren  = 1'b1;
			evt_q.push_back(evt_wdata);
		end
		repeat (rand_bits(2)) begin
			next_cycle();                                             // Record may trail its event
		end
		next_cycle();
		r         = rand_bits($bits(l1a_info_t));
		l1a_wdata = r[$bits(l1a_info_t)-1:0];
		l1a_wren  = 1'b1;
		l1a_q.push_back(l1a_wdata);
		events_pushed++;
	endtask

	task automatic wait_for_room();
		int n;
		n = 0;
		while (events_pushed - frames_done >= MAX_UNREAD) begin
			next_cycle();
			n++;
			if (n > ROOM_TIMEOUT) begin
				fail_run("timeout waiting for a pending frame to be read out");
			end
		end
	endtask

	task automatic wait_for_frames();
		int n;
		n = 0;
		while (frames_done < N_EVENTS) begin
			next_cycle();
			n++;
			if (n > FRAME_TIMEOUT) begin
				fail_run($sformatf("timeout with %0d of %0d frames seen", frames_done, N_EVENTS));
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// Frame monitor
	////////////////////////////////////////////////////////////
	task automatic observe_cycle(input logic [OCC_W-1:0] occ, input logic warn_bit);
		word_t     exp;
		evt_word_t ev;
		logic      is_data;
		ev      = '0;
		is_data = 1'b0;
		if (dvalid) begin
			if (word_idx == 0) begin
				if (prev_valid) begin
					fail_run("no idle cycle between two frames");
				end
				if (l1a_q.size() == 0) begin
					fail_run("frame started before a complete event was pushed");
				end
				cur_l1a = l1a_q[0];
				crc_m   = '0;
			end
			is_data = (word_idx >= HDR_WORDS) && (word_idx < HDR_WORDS + DATA_WORDS);
			if (is_data) begin
				if (evt_q.size() == 0) begin
					fail_run("data word with no pushed sample left");
				end
				ev = evt_q.pop_front();
			end
			exp = model_word(word_idx, cur_l1a, ev, crc_m, occ, warn_bit);
			if (word_idx == HDR_WORDS + DATA_WORDS) begin
				check_crc($sformatf("dout_o crc frame %0d", frames_done), dout[CRC_W-1:0], crc_m);
			end
			check_word($sformatf("dout_o frame %0d word %0d", frames_done, word_idx), dout, exp);
			if (is_data) begin
				crc_m = crc15_step({1'b0, ev.sample}, crc_m);
			end
		end else if (word_idx != 0) begin
			fail_run($sformatf("dvalid_o dropped after %0d words of a frame", word_idx));
		end
		check_flag("ovlp_mux_o", ovlp_mux, is_data && ev.ovlp);
		check_flag("mlt_ovlp_o", mlt_ovlp, is_data && ev.mlt_ovlp);
		check_flag("last_wrd_o", last_wrd, dvalid && (word_idx == FRAME_WORDS - 1));
		if (dvalid) begin
			if (word_idx == FRAME_WORDS - 1) begin
				word_idx = 0;
				void'(l1a_q.pop_front());
				frames_done++;
			end else begin
				word_idx++;
			end
		end
		prev_valid = dvalid;
	endtask

	initial begin
		logic [OCC_W-1:0] occ_exp;
		logic             warn_exp;
		forever begin
			@(posedge RCLK);
			occ_exp  = OCC_W'(l1a_pushes - lasts_seen);             // Counter value before this edge
			warn_exp = warn;
			if (!RST_RESYNC) begin
				if (l1a_wren) begin
					l1a_pushes++;
				end
				if (last_wrd) begin
					lasts_seen++;
				end
			end
			#1;
			if (!RST_RESYNC) begin
				observe_cycle(occ_exp, warn_exp);
			end
		end
	end

	initial begin
		lfsr_q        = LFSR_SEED;
		RST_RESYNC    = 1'b1;
		evt_wdata     = '0;
		evt_wren      = 1'b0;
		l1a_wdata     = '0;
		l1a_wren      = 1'b0;
		warn          = 1'b0;
		cur_l1a       = '0;
		crc_m         = '0;
		word_idx      = 0;
		frames_done   = 0;
		events_pushed = 0;
		l1a_pushes    = 0;
		lasts_seen    = 0;
		prev_valid    = 1'b0;
		repeat (4) @(posedge RCLK);
		#2;
		RST_RESYNC = 1'b0;
		for (int e = 0; e < N_EVENTS; e++) begin
			wait_for_room();
			push_event();
		end
		wait_for_frames();
		for (int i = 0; i < 2 * FRAME_WORDS; i++) begin
			next_cycle();                                             // No extra frame may appear
		end
		if (frames_done == N_EVENTS && evt_q.size() == 0 && l1a_q.size() == 0 && !dvalid) begin
			$display("test passed");
			$finish;
		end else begin
			fail_run($sformatf("run ended with %0d frames and %0d samples left over",
				frames_done, evt_q.size()));
		end
	end

endmodule

//--- chanlink_readout.f
+incdir+test
hdl/chanlink_pkg.sv
hdl/sync_fifo.sv
hdl/frame_sequencer.sv
hdl/frame_builder.sv
hdl/chanlink_readout.sv
test/chanlink_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the channel-link framer testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module chanlink_tb \
	-f chanlink_readout.f -Mdir obj_dir -o chanlink_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/chanlink_sim > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "test failed" sim.log; then
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi
exit 0
